//--- common/calc_cfg.svh
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// Project-wide sizing for the keypad calculator core

// Operand, result and display width
`define CALC_WIDTH 16

// One shift-and-add step per multiplier bit
`define MULT_STEPS `CALC_WIDTH

// Both operands and results wrap modulo 2**CALC_WIDTH,
// so no carry or overflow width is kept anywhere

`endif

//--- common/calc_pkg.sv
`default_nettype none

`include "calc_cfg.svh"

package calc_pkg;

    // Unsigned data word shared by operands, unit results and display
    typedef logic [`CALC_WIDTH-1:0] calc_word_t;

    // Operator keys, one-hot as the keypad sends them
    typedef enum logic [2:0] {
        OP_NONE = 3'b000,   // No operator pressed
        OP_ADD  = 3'b001,   // Addition
        OP_SUB  = 3'b010,   // Subtraction, wraps below zero
        OP_MUL  = 3'b100    // Multiplication, low word kept
    } calc_op_t;

    // Controller sequencing states
    typedef enum logic [2:0] {
        GET_FIRST   = 3'd0, // Collecting first operand digits
        GET_SECOND  = 3'd1, // Collecting second operand digits
        LAUNCH      = 3'd2, // Issue start to selected unit
        WAIT_UNIT   = 3'd3, // Wait for unit finish pulse
        SHOW_RESULT = 3'd4  // Complete pulse, then clear
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- common/calc_unit_if.sv
`default_nettype none

// Link between the controller and one arithmetic unit
interface calc_unit_if
    import calc_pkg::*;
();

    calc_word_t operand_a;  // First operand, held until finish
    calc_word_t operand_b;  // Second operand, held until finish
    logic       start;      // One-cycle launch strobe
    calc_word_t result;     // Valid from finish, held after
    logic       finish;     // One-cycle done strobe

    // Controller side
    modport ctrl (
        output operand_a,
        output operand_b,
        output start,
        input  result,
        input  finish
    );

    // Arithmetic unit side
    modport unit (
        input  operand_a,
        input  operand_b,
        input  start,
        output result,
        output finish
    );

endinterface

`default_nettype wire

//--- hdl/addsub_unit.sv
`default_nettype none

module addsub_unit
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic       sub,     // High selects a minus b
    calc_unit_if.unit  bus
);

    calc_word_t sum_w;  // Combinational add or subtract

    // Two's-complement wrap falls out of the fixed word width
    always_comb begin
        if (sub) begin
            sum_w = bus.operand_a - bus.operand_b;  // Wraps when b > a
        end else begin
            sum_w = bus.operand_a + bus.operand_b;  // Carry out dropped
        end
    end

    // Finish strobe trails start by one cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= bus.start;    // Single-cycle echo of start
        end
    end

    // Result register, only loaded on a start
    always_ff @(posedge clk) begin
        if (bus.start) begin
            bus.result <= sum_w;    // Held until next start
        end
    end

endmodule

`default_nettype wire

//--- multiplier/shift_add_multiplier.sv
`default_nettype none

`include "calc_cfg.svh"

module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    calc_unit_if.unit  bus
);

    localparam int CNT_W = $clog2(`MULT_STEPS + 1);  // Holds MULT_STEPS down to 0

    logic             busy;     // Iterations in progress
    logic [CNT_W-1:0] cnt;      // Steps left
    calc_word_t       mcand;    // Multiplicand, shifts left each step
    calc_word_t       mplier;   // Multiplier, shifts right each step
    calc_word_t       acc;      // Partial product, low word only
    calc_word_t       acc_next; // Accumulator after this step
    logic             load;     // Accepted start
    logic             last;     // Final iteration this cycle

    assign load = bus.start && !busy;   // Start while busy is dropped
    assign last = busy && (cnt == CNT_W'(1));

    // Add shifted multiplicand when the current multiplier bit is set
    always_comb begin
        if (mplier[0]) begin
            acc_next = acc + mcand;     // Upper bits fall off
        end else begin
            acc_next = acc;
        end
    end

    // Control: busy flag, step counter, finish strobe
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy       <= 1'b0;
            cnt        <= '0;
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= 1'b0;     // Pulse by default low
            if (load) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`MULT_STEPS);   // One load cycle, then the steps
            end else if (busy) begin
                cnt <= cnt - CNT_W'(1);
                if (last) begin
                    busy       <= 1'b0;
                    bus.finish <= 1'b1;     // Result lands the same edge
                end
            end
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (load) begin
            mcand  <= bus.operand_a;
            mplier <= bus.operand_b;
            acc    <= '0;       // Fresh product
        end else if (busy) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
            if (last) begin
                bus.result <= acc_next; // Held until the next product
            end
        end
    end

    // Multiplicand bits shifted past the word never reach the low result,
    // so the wrap modulo 2**CALC_WIDTH needs no extra masking

endmodule

`default_nettype wire

//--- hdl/calc_controller.sv
`default_nettype none

module calc_controller
    import calc_pkg::*;
(
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] keypad_input,    // Digit 1..9, 0 means no key
    input  calc_op_t   operator_input,  // One-hot operator key
    input  logic       equal_input,     // Equal key pulse
    calc_unit_if.ctrl  as_bus,          // Adder/subtractor link
    calc_unit_if.ctrl  mul_bus,         // Multiplier link
    output logic       sub,             // Subtract select to adder
    output logic       complete,        // One-cycle done pulse
    output calc_word_t display_output   // Last result
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    calc_word_t  operand_a;     // First operand under entry
    calc_word_t  operand_b;     // Second operand under entry
    calc_op_t    op_q;          // Latched operator
    logic        as_start;      // Registered start to adder
    logic        mul_start;     // Registered start to multiplier
    logic        key_hit;       // Nonzero digit this cycle
    logic        op_valid;      // Operator key is one-hot
    logic        unit_done;     // Either unit finished
    calc_word_t  key_word;      // Digit widened to a word

    assign key_hit  = (keypad_input != 4'd0);
    assign key_word = calc_word_t'(keypad_input);
    assign unit_done = as_bus.finish || mul_bus.finish;

    // Both units see the same operand registers
    assign as_bus.operand_a  = operand_a;
    assign as_bus.operand_b  = operand_b;
    assign as_bus.start      = as_start;
    assign mul_bus.operand_a = operand_a;
    assign mul_bus.operand_b = operand_b;
    assign mul_bus.start     = mul_start;

    // Only the three one-hot codes count as an operator
    always_comb begin
        case (operator_input)
            OP_ADD, OP_SUB, OP_MUL: op_valid = 1'b1;
            default:                op_valid = 1'b0;
        endcase
    end

    // Next-state logic
    always_comb begin
        next_state = state;     // Hold by default
        case (state)
            GET_FIRST: begin
                if (op_valid) begin
                    next_state = GET_SECOND;
                end
            end
            GET_SECOND: begin
                if (equal_input) begin
                    next_state = LAUNCH;
                end
            end
            LAUNCH: begin
                next_state = WAIT_UNIT;     // Start goes out on this edge
            end
            WAIT_UNIT: begin
                if (unit_done) begin
                    next_state = SHOW_RESULT;
                end
            end
            SHOW_RESULT: begin
                next_state = GET_FIRST;     // No chained calculation
            end
            default: begin
                next_state = GET_FIRST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= GET_FIRST;
            operand_a <= '0;
            operand_b <= '0;
            op_q      <= OP_NONE;
        end else begin
            state <= next_state;
            case (state)
                GET_FIRST: begin
                    // Times ten as x*8 + x*2, then add the digit
                    if (key_hit) begin
                        operand_a <= (operand_a << 3) + (operand_a << 1) + key_word;
                    end
                    if (op_valid) begin
                        op_q <= operator_input;
                    end
                end
                GET_SECOND: begin
                    if (key_hit) begin
                        operand_b <= (operand_b << 3) + (operand_b << 1) + key_word;
                    end
                end
                SHOW_RESULT: begin
                    operand_a <= '0;    // Ready for the next entry
                    operand_b <= '0;
                    op_q      <= OP_NONE;
                end
                default: begin
                    // Operands held steady while a unit works
                end
            endcase
        end
    end

    // Start strobes, subtract select, result capture
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            as_start       <= 1'b0;
            mul_start      <= 1'b0;
            sub            <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            as_start  <= 1'b0;  // Strobes are single-cycle
            mul_start <= 1'b0;
            complete  <= 1'b0;
            if (state == LAUNCH) begin
                case (op_q)
                    OP_ADD: begin
                        as_start <= 1'b1;
                        sub      <= 1'b0;
                    end
                    OP_SUB: begin
                        as_start <= 1'b1;
                        sub      <= 1'b1;
                    end
                    OP_MUL: begin
                        mul_start <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            if (state == WAIT_UNIT && unit_done) begin
                // Take the word from whichever unit reported
                display_output <= as_bus.finish ? as_bus.result : mul_bus.result;
                complete       <= 1'b1;     // High during SHOW_RESULT only
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/calc_top.sv
`default_nettype none

`include "calc_cfg.svh"

module calc_top
    import calc_pkg::*;
(
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [3:0]             keypad_input,    // Digit key, 0 when idle
    input  logic [2:0]             operator_input,  // One-hot operator key
    input  logic                   equal_input,     // Equal key pulse
    output logic                   complete,        // Result ready pulse
    output logic [`CALC_WIDTH-1:0] display_output   // Result word
);

    logic sub;  // Add or subtract select

    calc_unit_if as_bus ();     // Controller to adder/subtractor
    calc_unit_if mul_bus ();    // Controller to multiplier

    // Keypad sequencing and result selection
    calc_controller ctrl0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .operator_input (calc_op_t'(operator_input)),   // Non one-hot values rejected inside
        .equal_input    (equal_input),
        .as_bus         (as_bus.ctrl),
        .mul_bus        (mul_bus.ctrl),
        .sub            (sub),
        .complete       (complete),
        .display_output (display_output)
    );

    // Single-cycle add/subtract
    addsub_unit addsub0 (
        .clk  (clk),
        .nRST (nRST),
        .sub  (sub),
        .bus  (as_bus.unit)
    );

    // Iterative multiply, low word
    shift_add_multiplier mult0 (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus.unit)
    );

endmodule

`default_nettype wire

//--- verification/tb_calc_top.sv
`default_nettype none

`include "calc_cfg.svh"

module tb_calc_top
    import calc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ADD      = 200;
    localparam int NUM_SUB      = 80;
    localparam int NUM_MUL      = 80;
    localparam int NUM_MIX      = 100;
    localparam int NUM_CALCS    = NUM_ADD + NUM_SUB + NUM_MUL + NUM_MIX;
    localparam int CTRL_LAT     = 3;                        // Equal sample, launch, capture
    localparam int ADD_LAT      = CTRL_LAT + 1;             // Adder answers next cycle
    localparam int MUL_LAT      = CTRL_LAT + `MULT_STEPS + 1;   // Load plus all steps
    localparam int DONE_LIMIT   = `MULT_STEPS + 10;
    localparam int CALC_MAX_CYC = 10 * 5 + 5 + DONE_LIMIT + 2;  // Ten digits, gaps, op, equal
    localparam int WATCHDOG_NS  = (NUM_CALCS * CALC_MAX_CYC + 100) * 10;

    logic        clk;
    logic        nRST;
    logic [3:0]  keypad_input;
    logic [2:0]  operator_input;
    logic        equal_input;
    logic        complete;
    calc_word_t  display_output;

    logic [31:0] lfsr_state;        // Stimulus generator state
    int          errors;
    int          checks;
    int          completes_seen;    // Counted by the monitor
    int          equals_pressed;
    int          sub_wraps;         // Subtractions with b > a
    calc_word_t  last_result;       // Value display should hold
    logic        complete_q;        // Complete on previous falling edge

    calc_top dut0 (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Gather n bits, one step per bit
    function automatic int unsigned draw_bits(input int n);
        int unsigned v;
        int          i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    function automatic logic [3:0] draw_digit();
        logic [3:0] d;
        d = 4'(draw_bits(4));
        while (d == 4'd0 || d > 4'd9) begin
            d = 4'(draw_bits(4));   // Redraw, zero is no key
        end
        return d;
    endfunction

    // Two or three bits set, never one-hot
    function automatic logic [2:0] bogus_op();
        int unsigned v;
        v = draw_bits(2);
        return (v == 0) ? 3'b111 : (3'b111 ^ (3'b001 << (v - 1)));
    endfunction

    task automatic check_word(input calc_word_t exp, input calc_word_t act, input string what);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %0d got %0d", $time, what, exp, act);
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        checks++;
        if (act != exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %0d got %0d", $time, what, exp, act);
        end
    endtask

    task automatic press_digit(input logic [3:0] d);
        @(posedge clk);
        keypad_input   <= d;
        operator_input <= OP_NONE;
        @(posedge clk);
        keypad_input <= 4'd0;       // One-cycle key
    endtask

    // 0 to 3 idle cycles, rejected operator codes optional
    task automatic idle_gap(input logic junk_op);
        int g;
        g = draw_bits(2);
        repeat (g) begin
            @(posedge clk);
            operator_input <= (junk_op && draw_bits(1)) ? bogus_op() : OP_NONE;
        end
    endtask

    task automatic enter_number(input logic junk_op, output calc_word_t value);
        int         n;
        int         i;
        logic [3:0] d;
        value = '0;
        n = draw_bits(3);
        while (n == 0 || n > 5) begin
            n = draw_bits(3);
        end
        for (i = 0; i < n; i++) begin
            d = draw_digit();
            press_digit(d);
            value = value * calc_word_t'(10) + calc_word_t'(d);    // Wraps mod 2**16
            idle_gap(junk_op);
        end
    endtask

    // Random keys while the unit works, all must be ignored
    task automatic drive_in_flight();
        if (draw_bits(1)) begin
            keypad_input   <= draw_digit();
            operator_input <= 3'(draw_bits(3));
            equal_input    <= 1'b1;
        end else begin
            keypad_input   <= 4'd0;
            operator_input <= OP_NONE;
            equal_input    <= 1'b0;
        end
    endtask

    task automatic do_calc(input calc_op_t op);
        calc_word_t a;
        calc_word_t b;
        calc_word_t exp;
        int         cyc;
        int         lat;
        logic       done;
        enter_number(1'b1, a);
        @(posedge clk);
        operator_input <= op;
        @(posedge clk);
        operator_input <= OP_NONE;
        idle_gap(1'b0);
        enter_number(1'b0, b);
        case (op)
            OP_ADD:  exp = a + b;
            OP_SUB:  exp = a - b;   // Two's-complement wrap
            default: exp = a * b;   // Low word only
        endcase
        if (op == OP_SUB && b > a) begin
            sub_wraps++;
        end
        lat = (op == OP_MUL) ? MUL_LAT : ADD_LAT;
        @(negedge clk);
        check_word(last_result, display_output, "display held during entry");
        @(posedge clk);
        equal_input <= 1'b1;
        equals_pressed++;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < DONE_LIMIT) begin
            @(posedge clk);
            cyc++;
            drive_in_flight();
            @(negedge clk);
            done = complete;
            if (!done) begin
                check_word(last_result, display_output, "display held in flight");
            end
        end
        if (!done) begin
            errors++;
            $display("no complete pulse within %0d cycles of equal, at %0t ns", DONE_LIMIT, $time);
        end else begin
            check_count(lat, cyc, "cycles from equal to complete");
            check_word(exp, display_output, op.name());
        end
        last_result = exp;
        @(posedge clk);
        keypad_input   <= 4'd0;     // Clean inputs before GET_FIRST
        operator_input <= OP_NONE;
        equal_input    <= 1'b0;
    endtask

    task automatic run_test(input string name, input calc_op_t mode, input int n);
        int          err0;
        int          eq0;
        int          done0;
        int          i;
        int unsigned v;
        calc_op_t    op;
        err0  = errors;
        eq0   = equals_pressed;
        done0 = completes_seen;
        for (i = 0; i < n; i++) begin
            op = mode;
            if (mode == OP_NONE) begin
                v  = draw_bits(2);
                op = (v == 0) ? OP_ADD : (v == 1) ? OP_SUB : OP_MUL;   // 11 folds onto multiply
            end
            do_calc(op);
        end
        @(negedge clk);
        check_count(equals_pressed - eq0, completes_seen - done0, {name, " complete pulses"});
        $display("%-6s %0d calculations, %0d errors", name, n, errors - err0);
    endtask

    // Count complete pulses, flag any wider than one cycle
    always @(negedge clk) begin
        if (nRST && complete) begin
            completes_seen++;
            if (complete_q) begin
                errors++;
                $display("complete stayed high for more than one cycle at %0t ns", $time);
            end
        end
        complete_q = complete;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        lfsr_state     = 32'h0aa4_74e3;
        errors         = 0;
        checks         = 0;
        completes_seen = 0;
        equals_pressed = 0;
        sub_wraps      = 0;
        last_result    = '0;
        complete_q     = 1'b0;
        nRST           = 1'b0;
        keypad_input   = 4'd0;
        operator_input = OP_NONE;
        equal_input    = 1'b0;
        repeat (8) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        check_word('0, display_output, "display after reset");
        check_count(0, int'(complete), "complete after reset");
        $display("reset  outputs clear, %0d errors", errors);
        run_test("add", OP_ADD, NUM_ADD);
        run_test("sub", OP_SUB, NUM_SUB);
        if (sub_wraps == 0) begin
            errors++;
            $display("subtraction test never had a second operand above the first");
        end
        run_test("mul", OP_MUL, NUM_MUL);
        run_test("mixed", OP_NONE, NUM_MIX);
        repeat (4) @(posedge clk);
        $display("calculations %0d, checks %0d, errors %0d", equals_pressed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/calc_pkg.sv
common/calc_unit_if.sv
hdl/addsub_unit.sv
multiplier/shift_add_multiplier.sv
hdl/calc_controller.sv
hdl/calc_top.sv
verification/tb_calc_top.sv

//--- Bender.yml
package:
  name: calc_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/calc_pkg.sv
      - common/calc_unit_if.sv
      - hdl/addsub_unit.sv
      - multiplier/shift_add_multiplier.sv
      - hdl/calc_controller.sv
      - hdl/calc_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/tb_calc_top.sv
